//--- hw/lane_seq_params.svh
// Build-time constants of the lane sequencer, included by the package, the RTL and the testbench
`ifndef LANE_SEQ_PARAMS_SVH
`define LANE_SEQ_PARAMS_SVH

// Default number of lanes in the vector unit
`define LS_NR_LANES 4

// Number of instruction ids tracked by the main sequencer
`define LS_NR_VINSN 8

// Width of vl, vstart and every per-queue vl
`define LS_VL_W 16

// Vector register file size, the register index width follows from it
`define LS_NR_VREGS 32

// Operand queues served by this lane
`define LS_NR_OPQ 6
`define LS_VMASK_REG 0

`endif

//--- hw/lane_seq_pkg.sv
// Types exchanged between the lane sequencer blocks and its testbench, referenced by scoped name
`default_nettype none

`include "lane_seq_params.svh"

package lane_seq_pkg;

  typedef logic [$clog2(`LS_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`LS_NR_VREGS)-1:0] vreg_t;
  typedef logic [`LS_VL_W-1:0]             vlen_t;
  typedef logic [`LS_NR_VINSN-1:0]         insn_mask_t;
  // Scalar operand of vector-scalar forms
  typedef logic [15:0]                     scalar_t;

  typedef enum logic [1:0] {VFU_None, VFU_Alu, VFU_MFpu, VFU_StoreUnit} vfu_e;
  typedef enum logic [2:0] {VADD, VSUB, VMUL, VFADD, VSE} op_e;
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} ew_e;
  typedef enum logic [2:0] {AluA, AluB, MulFpuA, MulFpuB, StA, MaskM} opq_e;
  typedef enum logic {TgtAlu, TgtFpu} target_fu_e;

  // Instruction request from the main sequencer, vm set means unmasked
  typedef struct packed {
    vid_t       id;
    op_e        op;
    vfu_e       vfu;
    logic       vm;
    vreg_t      vs1;
    vreg_t      vs2;
    vreg_t      vd;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd;
    ew_e        eew_vs1;
    ew_e        eew_vs2;
    ew_e        vsew;
    vlen_t      vl;
    vlen_t      vstart;
    scalar_t    scalar_op;
    insn_mask_t hazard_vs1;
    insn_mask_t hazard_vs2;
    insn_mask_t hazard_vm;
    insn_mask_t hazard_vd;
  } pe_req_t;

  typedef struct packed {
    insn_mask_t vinsn_done;
  } pe_resp_t;

  // Operation handed to the lane's functional units, vl and vstart are this lane's share
  typedef struct packed {
    vid_t    id;
    op_e     op;
    logic    vm;
    vfu_e    vfu;
    vreg_t   vd;
    logic    use_vd;
    ew_e     vsew;
    scalar_t scalar_op;
    vlen_t   vl;
    vlen_t   vstart;
  } vfu_operation_t;

  typedef struct packed {
    vid_t       id;
    vreg_t      vs;
    ew_e        eew;
    vlen_t      vl;
    vlen_t      vstart;
    insn_mask_t hazard;
    target_fu_e target_fu;
  } opreq_cmd_t;

endpackage

`default_nettype wire

//--- hw/lane_seq_req_reg.sv
// One-entry fall-through buffer between the main sequencer and the lane dispatch logic
`default_nettype none
`timescale 1ns/1ns

module lane_seq_req_reg (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lane_seq_pkg::pe_req_t req_i,
  input  logic                  req_valid_i,
  input  logic                  take_i,
  output logic                  req_ready_o,
  output lane_seq_pkg::pe_req_t req_o,
  output logic                  req_valid_o
);

  lane_seq_pkg::pe_req_t req_q;
  logic                  full_q;

  // An empty buffer lets the incoming request straight through
  assign req_ready_o = !full_q;
  assign req_o       = full_q ? req_q : req_i;
  assign req_valid_o = full_q || req_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !take_i;
    end else begin
      // Keep the request when dispatch stalls on it
      full_q <= req_valid_i && !take_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && req_valid_i) begin
      req_q <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/lane_seq_dispatch.sv
// Issue logic of one lane: splits vl and vstart, builds operand commands and tracks ids
`default_nettype none
`timescale 1ns/1ns

`include "lane_seq_params.svh"

module lane_seq_dispatch #(
  parameter int unsigned NrLanes = `LS_NR_LANES
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [$clog2(NrLanes)-1:0]                    lane_id_i,
  input  lane_seq_pkg::pe_req_t                         req_i,
  input  logic                                          req_valid_i,
  input  logic [`LS_NR_OPQ-1:0]                         slot_busy_i,
  input  lane_seq_pkg::insn_mask_t                      vinsn_running_i,
  input  lane_seq_pkg::insn_mask_t                      alu_done_i,
  input  lane_seq_pkg::insn_mask_t                      mfpu_done_i,
  output logic                                          take_o,
  output logic [`LS_NR_OPQ-1:0]                         push_o,
  output lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0]     cmd_o,
  output lane_seq_pkg::vfu_operation_t                  vfu_operation_o,
  output logic                                          vfu_operation_valid_o,
  output lane_seq_pkg::pe_resp_t                        pe_resp_o,
  output logic                                          alu_vinsn_done_o,
  output logic                                          mfpu_vinsn_done_o
);

  localparam int unsigned LaneW = $clog2(NrLanes);
  // One mask byte covers eight elements in every lane
  localparam int unsigned MaskShift = LaneW + 3;

  lane_seq_pkg::vlen_t          lane_vl, lane_vstart, sta_vl, mask_vl;
  logic [`LS_NR_OPQ-1:0]        need, push_req;
  logic                         mute, issue, op_valid_d;
  lane_seq_pkg::insn_mask_t     running_kept, running_d, running_q, done_d, done_q;
  lane_seq_pkg::vfu_operation_t op_d;

  // Elements of n that fall on this lane, lanes below n mod N get one extra
  function automatic lane_seq_pkg::vlen_t lane_share(lane_seq_pkg::vlen_t n,
                                                     logic [LaneW-1:0] lane);
    lane_seq_pkg::vlen_t share;
    share = n >> LaneW;
    if (lane < n[LaneW-1:0]) share = share + 1'b1;
    return share;
  endfunction

  function automatic lane_seq_pkg::opreq_cmd_t mk_cmd(
    lane_seq_pkg::vid_t id_a, lane_seq_pkg::vreg_t vs_a, lane_seq_pkg::ew_e eew_a,
    lane_seq_pkg::vlen_t vl_a, lane_seq_pkg::vlen_t vstart_a,
    lane_seq_pkg::insn_mask_t hazard_a, lane_seq_pkg::target_fu_e tgt_a);
    return '{id: id_a, vs: vs_a, eew: eew_a, vl: vl_a, vstart: vstart_a,
             hazard: hazard_a, target_fu: tgt_a};
  endfunction

  ////////////////////////////////////////
  // Lane arithmetic
  ////////////////////////////////////////

  always_comb begin
    lane_vl     = lane_share(req_i.vl, lane_id_i);
    lane_vstart = lane_share(req_i.vstart, lane_id_i);
    // The store unit gathers from all lanes, so round up
    sta_vl      = (req_i.vl >> LaneW) + {{(`LS_VL_W-1){1'b0}}, |req_i.vl[LaneW-1:0]};
    mask_vl     = req_i.vl >> (MaskShift + int'(req_i.vsew));
    if ((mask_vl << (MaskShift + int'(req_i.vsew))) != req_i.vl) mask_vl = mask_vl + 1'b1;
  end

  // Queues each unit needs free, and the ones it actually fills
  always_comb begin
    need     = '0;
    push_req = '0;
    unique case (req_i.vfu)
      lane_seq_pkg::VFU_Alu: begin
        need[lane_seq_pkg::AluA]      = 1'b1;
        need[lane_seq_pkg::AluB]      = 1'b1;
        need[lane_seq_pkg::MaskM]     = 1'b1;
        push_req[lane_seq_pkg::AluA]  = req_i.use_vs1;
        push_req[lane_seq_pkg::AluB]  = req_i.use_vs2;
        push_req[lane_seq_pkg::MaskM] = !req_i.vm;
      end
      lane_seq_pkg::VFU_MFpu: begin
        need[lane_seq_pkg::MulFpuA]     = 1'b1;
        need[lane_seq_pkg::MulFpuB]     = 1'b1;
        need[lane_seq_pkg::MaskM]       = 1'b1;
        push_req[lane_seq_pkg::MulFpuA] = req_i.use_vs1;
        push_req[lane_seq_pkg::MulFpuB] = req_i.use_vs2;
        push_req[lane_seq_pkg::MaskM]   = !req_i.vm;
      end
      lane_seq_pkg::VFU_StoreUnit: begin
        need[lane_seq_pkg::StA]       = 1'b1;
        need[lane_seq_pkg::MaskM]     = 1'b1;
        push_req[lane_seq_pkg::StA]   = req_i.use_vs1;
        push_req[lane_seq_pkg::MaskM] = !req_i.vm;
      end
      default: ;
    endcase
  end

  // Commands are built for every queue, only the pushed ones are stored
  always_comb begin
    cmd_o[lane_seq_pkg::AluA] = mk_cmd(req_i.id, req_i.vs1, req_i.eew_vs1, lane_vl,
      lane_vstart, req_i.hazard_vs1 | req_i.hazard_vd, lane_seq_pkg::TgtAlu);
    cmd_o[lane_seq_pkg::AluB] = mk_cmd(req_i.id, req_i.vs2, req_i.eew_vs2, lane_vl,
      lane_vstart, req_i.hazard_vs2 | req_i.hazard_vd, lane_seq_pkg::TgtAlu);
    cmd_o[lane_seq_pkg::MulFpuA] = mk_cmd(req_i.id, req_i.vs1, req_i.eew_vs1, lane_vl,
      lane_vstart, req_i.hazard_vs1 | req_i.hazard_vd, lane_seq_pkg::TgtFpu);
    cmd_o[lane_seq_pkg::MulFpuB] = mk_cmd(req_i.id, req_i.vs2, req_i.eew_vs2, lane_vl,
      lane_vstart, req_i.hazard_vs2 | req_i.hazard_vd, lane_seq_pkg::TgtFpu);
    cmd_o[lane_seq_pkg::StA] = mk_cmd(req_i.id, req_i.vs1, req_i.eew_vs1, sta_vl,
      lane_vstart, req_i.hazard_vs1 | req_i.hazard_vd, lane_seq_pkg::TgtAlu);
    cmd_o[lane_seq_pkg::MaskM] = mk_cmd(req_i.id, lane_seq_pkg::vreg_t'(`LS_VMASK_REG),
      req_i.vsew, mask_vl, lane_vstart, req_i.hazard_vm | req_i.hazard_vd,
      lane_seq_pkg::TgtAlu);
  end

  ////////////////////////////////////////
  // Issue and id tracking
  ////////////////////////////////////////

  always_comb begin
    running_kept = running_q & vinsn_running_i;
    mute  = (req_i.vfu inside {lane_seq_pkg::VFU_Alu, lane_seq_pkg::VFU_MFpu}) &&
            (lane_vl == '0);
    issue = req_valid_i && !(|(need & slot_busy_i)) && !running_kept[req_i.id];

    take_o     = issue;
    push_o     = (issue && !mute) ? push_req : '0;
    op_valid_d = issue && !mute && (req_i.vfu != lane_seq_pkg::VFU_None);

    running_d = running_kept;
    if (op_valid_d) running_d[req_i.id] = 1'b1;

    // An empty lane finishes its share at once
    done_d = alu_done_i | mfpu_done_i;
    if (issue && mute) done_d[req_i.id] = 1'b1;

    op_d = '{id: req_i.id, op: req_i.op, vm: req_i.vm, vfu: req_i.vfu, vd: req_i.vd,
             use_vd: req_i.use_vd, vsew: req_i.vsew, scalar_op: req_i.scalar_op,
             vl: lane_vl, vstart: lane_vstart};
  end

  assign pe_resp_o.vinsn_done = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q             <= '0;
      done_q                <= '0;
      vfu_operation_valid_o <= 1'b0;
      alu_vinsn_done_o      <= 1'b0;
      mfpu_vinsn_done_o     <= 1'b0;
    end else begin
      running_q             <= running_d;
      done_q                <= done_d;
      vfu_operation_valid_o <= op_valid_d;
      alu_vinsn_done_o      <= |alu_done_i;
      mfpu_vinsn_done_o     <= |mfpu_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_d) begin
      vfu_operation_o <= op_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/lane_seq_opreq_slots.sv
// Per-queue holding registers for operand-request commands, drained by the operand requester
`default_nettype none
`timescale 1ns/1ns

`include "lane_seq_params.svh"

module lane_seq_opreq_slots (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [`LS_NR_OPQ-1:0]                     push_i,
  input  lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] cmd_i,
  input  logic [`LS_NR_OPQ-1:0]                     ready_i,
  output lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] cmd_o,
  output logic [`LS_NR_OPQ-1:0]                     valid_o
);

  lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] cmd_d;
  logic [`LS_NR_OPQ-1:0]                     valid_d;

  always_comb begin
    for (int q = 0; q < `LS_NR_OPQ; q++) begin
      cmd_d[q]   = ready_i[q] ? '0 : cmd_o[q];
      valid_d[q] = valid_o[q] && !ready_i[q];
      // A new command wins over the clear in the same cycle
      if (push_i[q]) begin
        cmd_d[q]   = cmd_i[q];
        valid_d[q] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      valid_o <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cmd_o <= cmd_d;
  end

endmodule

`default_nettype wire

//--- hw/lane_sequencer.sv
// Top level of the per-lane sequencer, instantiated once per lane of the vector unit
`default_nettype none
`timescale 1ns/1ns

`include "lane_seq_params.svh"

module lane_sequencer #(
  parameter int unsigned NrLanes = `LS_NR_LANES
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [$clog2(NrLanes)-1:0]                lane_id_i,
  // Main sequencer side
  input  lane_seq_pkg::pe_req_t                     pe_req_i,
  input  logic                                      pe_req_valid_i,
  input  lane_seq_pkg::insn_mask_t                  pe_vinsn_running_i,
  output logic                                      pe_req_ready_o,
  output lane_seq_pkg::pe_resp_t                    pe_resp_o,
  // Operand requester side
  output lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] operand_request_o,
  output logic [`LS_NR_OPQ-1:0]                     operand_request_valid_o,
  input  logic [`LS_NR_OPQ-1:0]                     operand_request_ready_i,
  // Functional unit side
  output lane_seq_pkg::vfu_operation_t              vfu_operation_o,
  output logic                                      vfu_operation_valid_o,
  input  lane_seq_pkg::insn_mask_t                  alu_vinsn_done_i,
  input  lane_seq_pkg::insn_mask_t                  mfpu_vinsn_done_i,
  output logic                                      alu_vinsn_done_o,
  output logic                                      mfpu_vinsn_done_o
);

  lane_seq_pkg::pe_req_t                     req;
  logic                                      req_valid, take;
  logic [`LS_NR_OPQ-1:0]                     push;
  lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] cmd;

  lane_seq_req_reg req_reg_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(pe_req_i), .req_valid_i(pe_req_valid_i),
    .take_i(take), .req_ready_o(pe_req_ready_o), .req_o(req), .req_valid_o(req_valid)
  );

  lane_seq_dispatch #(.NrLanes(NrLanes)) dispatch_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .lane_id_i(lane_id_i), .req_i(req),
    .req_valid_i(req_valid), .slot_busy_i(operand_request_valid_o),
    .vinsn_running_i(pe_vinsn_running_i), .alu_done_i(alu_vinsn_done_i),
    .mfpu_done_i(mfpu_vinsn_done_i), .take_o(take), .push_o(push), .cmd_o(cmd),
    .vfu_operation_o(vfu_operation_o), .vfu_operation_valid_o(vfu_operation_valid_o),
    .pe_resp_o(pe_resp_o), .alu_vinsn_done_o(alu_vinsn_done_o),
    .mfpu_vinsn_done_o(mfpu_vinsn_done_o)
  );

  lane_seq_opreq_slots slots_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(push), .cmd_i(cmd),
    .ready_i(operand_request_ready_i), .cmd_o(operand_request_o),
    .valid_o(operand_request_valid_o)
  );

endmodule

`default_nettype wire

//--- tb/lane_seq_assert.sv
// Concurrent protocol checks on the lane sequencer outputs, bound to the top level from the testbench
`default_nettype none
`timescale 1ns/1ns

`include "lane_seq_params.svh"

module lane_seq_assert (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input lane_seq_pkg::vfu_operation_t              vfu_operation_o,
  input logic                                      vfu_operation_valid_o,
  input lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] operand_request_o,
  input logic [`LS_NR_OPQ-1:0]                     operand_request_valid_o,
  input logic [`LS_NR_OPQ-1:0]                     operand_request_ready_i,
  input logic                                      pe_req_ready_o,
  input lane_seq_pkg::pe_resp_t                    pe_resp_o
);

  // An operation pulse always names a real unit
  op_has_unit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vfu_operation_valid_o |-> vfu_operation_o.vfu != lane_seq_pkg::VFU_None)
    else $error("operation issued with no target unit");

  // A waiting slot keeps its command until the operand requester takes it
  for (genvar q = 0; q < `LS_NR_OPQ; q++) begin : g_slot
    slot_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_request_valid_o[q] && !operand_request_ready_i[q] |=>
        operand_request_valid_o[q] && $stable(operand_request_o[q]))
      else $error("operand request slot %0d changed while waiting", q);
  end

  reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |->
    !vfu_operation_valid_o && operand_request_valid_o == '0 && pe_req_ready_o &&
    pe_resp_o.vinsn_done == '0)
    else $error("outputs not idle after reset");

endmodule

`default_nettype wire

//--- tb/tb_lane_sequencer.sv
// Directed testbench for the lane sequencer that the Makefile builds and runs from the file list
`default_nettype none
`timescale 1ns/1ns

`include "lane_seq_params.svh"

module tb_lane_sequencer;

  localparam int NR = `LS_NR_LANES;
  // Cycles for reset and for each test in turn
  localparam int TEST_CYCLES    = 3 + 4 * 6 + 6 + 6 + 20 + 30;
  // Four times the expected length of the run
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  typedef logic [$clog2(NR)-1:0] lane_t;

  logic                                      clk_i, rst_ni;
  lane_t                                     lane_id_i;
  lane_seq_pkg::pe_req_t                     pe_req_i;
  logic                                      pe_req_valid_i, pe_req_ready_o;
  lane_seq_pkg::insn_mask_t                  pe_vinsn_running_i;
  lane_seq_pkg::insn_mask_t                  alu_vinsn_done_i, mfpu_vinsn_done_i;
  lane_seq_pkg::pe_resp_t                    pe_resp_o;
  lane_seq_pkg::opreq_cmd_t [`LS_NR_OPQ-1:0] operand_request_o;
  logic [`LS_NR_OPQ-1:0]                     operand_request_valid_o, operand_request_ready_i;
  lane_seq_pkg::vfu_operation_t              vfu_operation_o;
  logic                                      vfu_operation_valid_o;
  logic                                      alu_vinsn_done_o, mfpu_vinsn_done_o;
  int                                        checks, errors, tests, cycles;
  integer                                    seed;

  lane_sequencer #(.NrLanes(NR)) lane_sequencer_inst (.*);

  bind lane_sequencer lane_seq_assert lane_seq_assert_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .vfu_operation_o(vfu_operation_o),
    .vfu_operation_valid_o(vfu_operation_valid_o), .operand_request_o(operand_request_o),
    .operand_request_valid_o(operand_request_valid_o),
    .operand_request_ready_i(operand_request_ready_i), .pe_req_ready_o(pe_req_ready_o),
    .pe_resp_o(pe_resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Elements of n that land on a lane when they are dealt out round robin
  function automatic int lane_count(input int n, input int lane);
    return n / NR + ((lane < n % NR) ? 1 : 0);
  endfunction

  // One element of width sew holds 8 << sew mask bits in each of the NR lanes
  function automatic int mask_count(input int vl, input int sew);
    int span;
    span = NR * 8 * (1 << sew);
    return (vl + span - 1) / span;
  endfunction

  function automatic lane_seq_pkg::pe_req_t build_req(input int id, input lane_seq_pkg::vfu_e vfu,
                                                      input lane_seq_pkg::op_e op, input int vl,
                                                      input int vstart);
    lane_seq_pkg::pe_req_t r;
    r            = '0;
    r.id         = lane_seq_pkg::vid_t'(id);
    r.op         = op;
    r.vfu        = vfu;
    r.vm         = 1'b1;
    r.vs1        = 5'd5;
    r.vs2        = 5'd9;
    r.vd         = 5'd12;
    r.use_vs1    = 1'b1;
    r.use_vs2    = 1'b1;
    r.use_vd     = 1'b1;
    r.eew_vs1    = lane_seq_pkg::EW32;
    r.eew_vs2    = lane_seq_pkg::EW16;
    r.vsew       = lane_seq_pkg::EW32;
    r.vl         = lane_seq_pkg::vlen_t'(vl);
    r.vstart     = lane_seq_pkg::vlen_t'(vstart);
    r.scalar_op  = 16'h5a3c;
    r.hazard_vs1 = 8'h12;
    r.hazard_vs2 = 8'h24;
    r.hazard_vm  = 8'h40;
    r.hazard_vd  = 8'h81;
    return r;
  endfunction

  function automatic lane_seq_pkg::vfu_operation_t expected_op(input lane_seq_pkg::pe_req_t r,
                                                               input int lane);
    lane_seq_pkg::vfu_operation_t op;
    op.id        = r.id;
    op.op        = r.op;
    op.vm        = r.vm;
    op.vfu       = r.vfu;
    op.vd        = r.vd;
    op.use_vd    = r.use_vd;
    op.vsew      = r.vsew;
    op.scalar_op = r.scalar_op;
    op.vl        = lane_seq_pkg::vlen_t'(lane_count(int'(r.vl), lane));
    op.vstart    = lane_seq_pkg::vlen_t'(lane_count(int'(r.vstart), lane));
    return op;
  endfunction

  // The source hazard is widened by the destination hazard of the same instruction
  function automatic lane_seq_pkg::opreq_cmd_t expected_cmd(
    input lane_seq_pkg::pe_req_t r, input lane_seq_pkg::vreg_t vs, input lane_seq_pkg::ew_e eew,
    input int vl, input int lane, input lane_seq_pkg::insn_mask_t hazard,
    input lane_seq_pkg::target_fu_e tgt);
    lane_seq_pkg::opreq_cmd_t c;
    c.id        = r.id;
    c.vs        = vs;
    c.eew       = eew;
    c.vl        = lane_seq_pkg::vlen_t'(vl);
    c.vstart    = lane_seq_pkg::vlen_t'(lane_count(int'(r.vstart), lane));
    c.hazard    = hazard | r.hazard_vd;
    c.target_fu = tgt;
    return c;
  endfunction

  ////////////////////////////////////////
  // Compare and drive helpers
  ////////////////////////////////////////

  task automatic check_op(input lane_seq_pkg::vfu_operation_t got,
                          input lane_seq_pkg::vfu_operation_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input lane_seq_pkg::opreq_cmd_t got,
                           input lane_seq_pkg::opreq_cmd_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input lane_seq_pkg::pe_resp_t got,
                            input lane_seq_pkg::pe_resp_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_slot(input lane_seq_pkg::opq_e q, input logic exp_valid,
                            input lane_seq_pkg::opreq_cmd_t exp_cmd);
    check_flag(operand_request_valid_o[q], exp_valid,
               {"operand_request_valid_o[", q.name(), "]"});
    if (exp_valid) begin
      check_cmd(operand_request_o[q], exp_cmd, {"operand_request_o[", q.name(), "]"});
    end
  endtask

  // Source A reads vs1 and source B reads vs2 with this lane's share of vl
  task automatic check_pair(input lane_seq_pkg::pe_req_t r, input int lane,
                            input lane_seq_pkg::opq_e qa, input lane_seq_pkg::opq_e qb,
                            input lane_seq_pkg::target_fu_e tgt);
    int vl;
    vl = lane_count(int'(r.vl), lane);
    check_slot(qa, r.use_vs1, expected_cmd(r, r.vs1, r.eew_vs1, vl, lane, r.hazard_vs1, tgt));
    check_slot(qb, r.use_vs2, expected_cmd(r, r.vs2, r.eew_vs2, vl, lane, r.hazard_vs2, tgt));
  endtask

  // A held request must not issue on any of the n cycles it waits
  task automatic check_stalled(input int n);
    repeat (n) begin
      @(negedge clk_i);
      check_flag(vfu_operation_valid_o, 1'b0, "vfu_operation_valid_o");
    end
    check_flag(pe_req_ready_o, 1'b0, "pe_req_ready_o");
  endtask

  // Holds the request until the input register accepts it
  task automatic send_req(input lane_seq_pkg::pe_req_t r);
    @(posedge clk_i);
    pe_req_i       <= r;
    pe_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
  endtask

  task automatic wait_op(input int limit);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!vfu_operation_valid_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    checks++;
    if (!vfu_operation_valid_o) begin
      errors++;
      $display("no operation was issued within %0d cycles", limit);
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    $display("test %s: %s, %0d errors", name, (errors == start_err) ? "ok" : "failed",
             errors - start_err);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_alu_lanes();
    lane_seq_pkg::pe_req_t r;
    int                    start_err;
    start_err = errors;
    for (int lane = 0; lane < NR; lane++) begin
      r = build_req(lane, lane_seq_pkg::VFU_Alu, lane_seq_pkg::VADD,
                    4 + ($random(seed) & 255), $random(seed) & 63);
      r.use_vs2 = lane[0];
      @(posedge clk_i);
      lane_id_i <= lane_t'(lane);
      send_req(r);
      @(negedge clk_i);
      check_flag(vfu_operation_valid_o, 1'b1, "vfu_operation_valid_o");
      check_op(vfu_operation_o, expected_op(r, lane), "vfu_operation_o");
      check_pair(r, lane, lane_seq_pkg::AluA, lane_seq_pkg::AluB, lane_seq_pkg::TgtAlu);
      check_slot(lane_seq_pkg::MaskM, 1'b0, '0);
    end
    report_test("alu vadd on every lane", start_err);
  endtask

  task automatic test_fpu_masked();
    lane_seq_pkg::pe_req_t r;
    int                    start_err;
    start_err = errors;
    r = build_req(1, lane_seq_pkg::VFU_MFpu, lane_seq_pkg::VFADD,
                  4 + ($random(seed) & 511), $random(seed) & 15);
    r.vm   = 1'b0;
    r.vsew = lane_seq_pkg::EW16;
    @(posedge clk_i);
    lane_id_i <= lane_t'(2);
    send_req(r);
    @(negedge clk_i);
    check_op(vfu_operation_o, expected_op(r, 2), "vfu_operation_o");
    check_pair(r, 2, lane_seq_pkg::MulFpuA, lane_seq_pkg::MulFpuB, lane_seq_pkg::TgtFpu);
    check_slot(lane_seq_pkg::MaskM, 1'b1,
               expected_cmd(r, lane_seq_pkg::vreg_t'(`LS_VMASK_REG), r.vsew,
                            mask_count(int'(r.vl), int'(r.vsew)), 2, r.hazard_vm,
                            lane_seq_pkg::TgtAlu));
    report_test("masked fpu vfadd", start_err);
  endtask

  task automatic test_store();
    lane_seq_pkg::pe_req_t r;
    int                    start_err;
    start_err = errors;
    r = build_req(3, lane_seq_pkg::VFU_StoreUnit, lane_seq_pkg::VSE,
                  1 + ($random(seed) & 255), 0);
    r.use_vs2 = 1'b0;
    @(posedge clk_i);
    lane_id_i <= lane_t'(1);
    send_req(r);
    @(negedge clk_i);
    check_flag(vfu_operation_valid_o, 1'b1, "vfu_operation_valid_o");
    check_op(vfu_operation_o, expected_op(r, 1), "vfu_operation_o");
    check_slot(lane_seq_pkg::StA, 1'b1,
               expected_cmd(r, r.vs1, r.eew_vs1, (int'(r.vl) + NR - 1) / NR, 1, r.hazard_vs1,
                            lane_seq_pkg::TgtAlu));
    report_test("store vse", start_err);
  endtask

  task automatic test_backpressure();
    lane_seq_pkg::pe_req_t r_a, r_b;
    int                    start_err;
    start_err = errors;
    r_a = build_req(2, lane_seq_pkg::VFU_Alu, lane_seq_pkg::VADD, 4 + ($random(seed) & 255), 0);
    r_b = build_req(3, lane_seq_pkg::VFU_Alu, lane_seq_pkg::VSUB, 4 + ($random(seed) & 255), 4);
    r_b.vs1 = 5'd7;
    @(posedge clk_i);
    lane_id_i               <= '0;
    operand_request_ready_i <= '0;
    send_req(r_a);
    @(negedge clk_i);
    check_flag(vfu_operation_valid_o, 1'b1, "vfu_operation_valid_o");
    // The second request is accepted into the register but cannot issue
    send_req(r_b);
    check_stalled(3);
    check_pair(r_a, 0, lane_seq_pkg::AluA, lane_seq_pkg::AluB, lane_seq_pkg::TgtAlu);
    @(posedge clk_i);
    operand_request_ready_i <= '1;
    @(posedge clk_i);
    operand_request_ready_i <= '0;
    wait_op(4);
    check_op(vfu_operation_o, expected_op(r_b, 0), "vfu_operation_o");
    check_pair(r_b, 0, lane_seq_pkg::AluA, lane_seq_pkg::AluB, lane_seq_pkg::TgtAlu);
    check_flag(pe_req_ready_o, 1'b1, "pe_req_ready_o");
    @(posedge clk_i);
    operand_request_ready_i <= '1;
    report_test("back-pressure from busy slots", start_err);
  endtask

  task automatic test_completion();
    lane_seq_pkg::pe_req_t  r, r2;
    lane_seq_pkg::pe_resp_t exp_resp;
    int                     start_err;
    start_err = errors;
    // Two elements leave lane 3 empty
    r = build_req(5, lane_seq_pkg::VFU_Alu, lane_seq_pkg::VADD, 2, 0);
    @(posedge clk_i);
    lane_id_i <= lane_t'(3);
    send_req(r);
    @(negedge clk_i);
    exp_resp.vinsn_done = 8'h20;
    check_flag(vfu_operation_valid_o, 1'b0, "vfu_operation_valid_o");
    check_resp(pe_resp_o, exp_resp, "pe_resp_o");
    check_slot(lane_seq_pkg::AluA, 1'b0, '0);
    check_slot(lane_seq_pkg::AluB, 1'b0, '0);
    @(posedge clk_i);
    alu_vinsn_done_i <= 8'h10;
    @(posedge clk_i);
    alu_vinsn_done_i <= '0;
    @(negedge clk_i);
    exp_resp.vinsn_done = 8'h10;
    check_resp(pe_resp_o, exp_resp, "pe_resp_o");
    check_flag(alu_vinsn_done_o, 1'b1, "alu_vinsn_done_o");
    check_flag(mfpu_vinsn_done_o, 1'b0, "mfpu_vinsn_done_o");
    @(posedge clk_i);
    mfpu_vinsn_done_i <= 8'h04;
    @(posedge clk_i);
    mfpu_vinsn_done_i <= '0;
    @(negedge clk_i);
    exp_resp.vinsn_done = 8'h04;
    check_resp(pe_resp_o, exp_resp, "pe_resp_o");
    check_flag(alu_vinsn_done_o, 1'b0, "alu_vinsn_done_o");
    check_flag(mfpu_vinsn_done_o, 1'b1, "mfpu_vinsn_done_o");
    // Reusing id 6 must wait while the main sequencer still reports it running
    r = build_req(6, lane_seq_pkg::VFU_Alu, lane_seq_pkg::VSUB, 8, 0);
    r2 = r;
    r2.op = lane_seq_pkg::VADD;
    r2.vd = 5'd20;
    @(posedge clk_i);
    lane_id_i          <= '0;
    pe_vinsn_running_i <= 8'h40;
    send_req(r);
    @(negedge clk_i);
    check_flag(vfu_operation_valid_o, 1'b1, "vfu_operation_valid_o");
    send_req(r2);
    check_stalled(3);
    @(posedge clk_i);
    pe_vinsn_running_i <= '0;
    wait_op(4);
    check_op(vfu_operation_o, expected_op(r2, 0), "vfu_operation_o");
    report_test("mute, done strobe and running id", start_err);
  endtask

  initial begin
    seed                    = 15949;
    rst_ni                  = 1'b0;
    lane_id_i               = '0;
    pe_req_i                = '0;
    pe_req_valid_i          = 1'b0;
    pe_vinsn_running_i      = '0;
    operand_request_ready_i = '1;
    alu_vinsn_done_i        = '0;
    mfpu_vinsn_done_i       = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_alu_lanes();
    test_fpu_masked();
    test_store();
    test_backpressure();
    test_completion();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lane_seq.f
+incdir+hw
hw/lane_seq_pkg.sv
hw/lane_seq_req_reg.sv
hw/lane_seq_dispatch.sv
hw/lane_seq_opreq_slots.sv
hw/lane_sequencer.sv
tb/lane_seq_assert.sv
tb/tb_lane_sequencer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lane_sequencer
FILELIST  ?= lane_seq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Shows the simulation output and fails unless the pass line is present
run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
